// File: verilog/memGeomPkg.sv
/*
 * memory geometry for the banked instruction/data memory
 * word size, bank layout and how a byte address splits into fields
 */
package memGeomPkg;

	// data word and its byte lanes
	localparam int wordBits = 32;
	localparam int byteLanes = 4;

	// word-interleaved banks
	localparam int bankCount = 4;
	localparam int bankBits = 2;

	// words held by each bank
	localparam int bankDepth = 1024;
	localparam int rowBits = 10;

	// byte address as seen at the ports
	localparam int addrBits = 32;

	// byte offset inside a word, dropped before bank decode
	localparam int offsetBits = 2;

	// word address layout above the offset:
	//   [offsetBits +: bankBits]           bank select
	//   [offsetBits + bankBits +: rowBits] row inside the bank
	// anything above the row is ignored, so memory aliases

endpackage : memGeomPkg

// File: verilog/memXactPkg.sv
/*
 * transaction types shared by arbiter, banks and collector
 * requester identity and the access handed to one bank
 */
package memXactPkg;

	// which port an access belongs to
	// values double as index into per-port vectors
	typedef enum logic {
		reqFetch = 1'b0,
		reqData = 1'b1
	} requesterT;

	// one access into a bank
	typedef struct packed {
		// word inside the bank
		logic [memGeomPkg::rowBits-1:0] row;
		// write enable, reads happen on every access
		logic we;
		// byte lanes to update when we is set
		logic [memGeomPkg::byteLanes-1:0] be;
		// write word
		logic [memGeomPkg::wordBits-1:0] wdata;
	} bankAccessT;

	// fetch accesses carry we and be cleared
	// data accesses pass the port fields through unchanged

	// 47 bits in the default geometry:
	// 10 row + 1 we + 4 be + 32 wdata

endpackage : memXactPkg

// File: verilog/memBankIf.sv
/*
 * link into one memory bank
 * carries an access in and the read word with its owner back out
 */
interface memBankIf;

	// request side, from the arbiter
	logic valid;
	memXactPkg::bankAccessT access;
	memXactPkg::requesterT owner;

	// response side, from the bank one cycle later
	logic [memGeomPkg::wordBits-1:0] rdata;
	logic done;
	memXactPkg::requesterT doneOwner;

	// arbiter drives accesses
	modport issue (
		output valid,
		output access,
		output owner
	);

	// bank takes accesses and returns data
	modport bank (
		input valid,
		input access,
		input owner,
		output rdata,
		output done,
		output doneOwner
	);

	// collector only looks at the response
	modport drain (
		input rdata,
		input done,
		input doneOwner
	);

endinterface : memBankIf

// File: verilog/portArbiter.sv
/*
 * port arbiter for fetch and data requests
 * decodes banks, alternates priority on conflicts and drives the bank links
 */
module portArbiter (
	input logic clk,
	input logic rst,
	input logic fetchReq,
	input logic [memGeomPkg::addrBits-1:0] fetchAddr,
	input logic dataReq,
	input logic dataWe,
	input logic [memGeomPkg::byteLanes-1:0] dataBe,
	input logic [memGeomPkg::addrBits-1:0] dataAddr,
	input logic [memGeomPkg::wordBits-1:0] dataWdata,
	input logic fetchAck,
	input logic dataAck,
	input logic [1:0] served,
	memBankIf.issue banks [memGeomPkg::bankCount]
);

	// per-port vectors, indexed by requesterT
	logic [1:0] req;
	logic [1:0] ack;
	logic [1:0] elig;
	logic [1:0] grant;
	// issued stays set until the handshake closes
	logic [1:0] issued;
	// answered mirrors the collector's ack
	logic [1:0] answered;

	logic [memGeomPkg::bankBits-1:0] fetchBank;
	logic [memGeomPkg::bankBits-1:0] dataBank;
	memXactPkg::bankAccessT fetchAccess;
	memXactPkg::bankAccessT dataAccess;
	logic conflict;
	// which port wins the next same-bank conflict
	memXactPkg::requesterT prio;

	assign req = {dataReq, fetchReq};
	assign ack = {dataAck, fetchAck};

	// bank select sits right above the byte offset
	assign fetchBank = fetchAddr[memGeomPkg::offsetBits +: memGeomPkg::bankBits];
	assign dataBank = dataAddr[memGeomPkg::offsetBits +: memGeomPkg::bankBits];

	// fetch is read only
	assign fetchAccess.row =
		fetchAddr[memGeomPkg::offsetBits + memGeomPkg::bankBits +: memGeomPkg::rowBits];
	assign fetchAccess.we = 1'b0;
	assign fetchAccess.be = '0;
	assign fetchAccess.wdata = '0;

	assign dataAccess.row =
		dataAddr[memGeomPkg::offsetBits + memGeomPkg::bankBits +: memGeomPkg::rowBits];
	assign dataAccess.we = dataWe;
	assign dataAccess.be = dataBe;
	assign dataAccess.wdata = dataWdata;

	// a port may issue once per request, and not while acked
	assign elig = req & ~ack & ~issued;
	assign conflict = elig[memXactPkg::reqFetch] && elig[memXactPkg::reqData] &&
		fetchBank == dataBank;

	// loser of a conflict waits one cycle, then it holds priority
	assign grant[memXactPkg::reqFetch] = elig[memXactPkg::reqFetch] &&
		(!conflict || prio == memXactPkg::reqFetch);
	assign grant[memXactPkg::reqData] = elig[memXactPkg::reqData] &&
		(!conflict || prio == memXactPkg::reqData);

	// drive every bank link, data wins the mux only when it owns that bank
	for (genvar b = 0; b < memGeomPkg::bankCount; b++) begin : gIssue
		logic fetchHere;
		logic dataHere;

		assign fetchHere = grant[memXactPkg::reqFetch] && fetchBank == b;
		assign dataHere = grant[memXactPkg::reqData] && dataBank == b;

		assign banks[b].valid = fetchHere || dataHere;
		assign banks[b].owner = dataHere ? memXactPkg::reqData : memXactPkg::reqFetch;
		assign banks[b].access = dataHere ? dataAccess : fetchAccess;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			issued <= '0;
			answered <= '0;
			prio <= memXactPkg::reqFetch;
		end else begin
			// flip only when someone actually lost
			if (conflict) begin
				prio <= (prio == memXactPkg::reqFetch) ? memXactPkg::reqData :
					memXactPkg::reqFetch;
			end
			for (int p = 0; p < 2; p++) begin
				// closes at the same edge the collector drops ack
				if (grant[p]) begin
					issued[p] <= 1'b1;
				end else if (answered[p] && !req[p]) begin
					issued[p] <= 1'b0;
				end
				if (served[p]) begin
					answered[p] <= 1'b1;
				end else if (answered[p] && !req[p]) begin
					answered[p] <= 1'b0;
				end
			end
		end
	end

endmodule : portArbiter

// File: verilog/memBank.sv
/*
 * single synchronous RAM bank
 * byte-lane writes, old word returned on every access
 */
module memBank (
	input logic clk,
	memBankIf.bank port
);

	// storage, no reset on contents
	logic [memGeomPkg::wordBits-1:0] mem [memGeomPkg::bankDepth];

	// lane-sliced write plus read of the old word
	always_ff @(posedge clk) begin
		if (port.valid) begin
			if (port.access.we) begin
				for (int lane = 0; lane < memGeomPkg::byteLanes; lane++) begin
					// only enabled lanes change
					if (port.access.be[lane]) begin
						mem[port.access.row][lane * (memGeomPkg::wordBits /
							memGeomPkg::byteLanes) +: (memGeomPkg::wordBits /
							memGeomPkg::byteLanes)] <=
							port.access.wdata[lane * (memGeomPkg::wordBits /
							memGeomPkg::byteLanes) +: (memGeomPkg::wordBits /
							memGeomPkg::byteLanes)];
					end
				end
			end
			// read-before-write, a write returns the previous contents
			port.rdata <= mem[port.access.row];
		end
	end

	// done follows valid by one cycle
	// owner travels along so the collector can route the word
	always_ff @(posedge clk) begin
		port.done <= port.valid;
		port.doneOwner <= port.owner;
	end

endmodule : memBank

// File: verilog/responseCollector.sv
/*
 * response collector
 * routes finished bank reads to their port and runs the ack side of req/ack
 */
module responseCollector (
	input logic clk,
	input logic rst,
	memBankIf.drain banks [memGeomPkg::bankCount],
	input logic fetchReq,
	input logic dataReq,
	output logic fetchAck,
	output logic [memGeomPkg::wordBits-1:0] fetchData,
	output logic dataAck,
	output logic [memGeomPkg::wordBits-1:0] dataRdata,
	output logic [1:0] served
);

	// flattened view of the bank responses
	logic [memGeomPkg::wordBits-1:0] bankData [memGeomPkg::bankCount];
	logic [memGeomPkg::bankCount-1:0] fetchHit;
	logic [memGeomPkg::bankCount-1:0] dataHit;
	// selected word per port
	logic [memGeomPkg::wordBits-1:0] fetchSel;
	logic [memGeomPkg::wordBits-1:0] dataSel;

	for (genvar b = 0; b < memGeomPkg::bankCount; b++) begin : gDrain
		assign bankData[b] = banks[b].rdata;
		assign fetchHit[b] = banks[b].done && banks[b].doneOwner == memXactPkg::reqFetch;
		assign dataHit[b] = banks[b].done && banks[b].doneOwner == memXactPkg::reqData;
	end

	// at most one bank per port finishes in a cycle
	// since each port has one access in flight
	always_comb begin
		fetchSel = '0;
		dataSel = '0;
		for (int b = 0; b < memGeomPkg::bankCount; b++) begin
			if (fetchHit[b]) fetchSel = bankData[b];
			if (dataHit[b]) dataSel = bankData[b];
		end
	end

	// data registers hold while ack is up, nothing new arrives until req/ack closes
	always_ff @(posedge clk) begin
		if (|fetchHit) fetchData <= fetchSel;
		if (|dataHit) dataRdata <= dataSel;
	end

	// ack rises with the captured word, drops once req is seen low
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchAck <= 1'b0;
			dataAck <= 1'b0;
			served <= '0;
		end else begin
			if (|fetchHit) begin
				fetchAck <= 1'b1;
			end else if (!fetchReq) begin
				fetchAck <= 1'b0;
			end
			if (|dataHit) begin
				dataAck <= 1'b1;
			end else if (!dataReq) begin
				dataAck <= 1'b0;
			end
			// one-cycle pulse tells the arbiter the response landed
			served[memXactPkg::reqFetch] <= |fetchHit;
			served[memXactPkg::reqData] <= |dataHit;
		end
	end

endmodule : responseCollector

// File: verilog/memSystem.sv
/*
 * banked instruction/data memory with fetch and data ports
 * arbiter, bank array and response collector behind plain req/ack ports
 */
module memSystem (
	input logic clk,
	input logic rst,
	// instruction fetch, read only
	input logic fetchReq,
	input logic [memGeomPkg::addrBits-1:0] fetchAddr,
	output logic fetchAck,
	output logic [memGeomPkg::wordBits-1:0] fetchData,
	// data port, read/write with byte enables
	input logic dataReq,
	input logic dataWe,
	input logic [memGeomPkg::byteLanes-1:0] dataBe,
	input logic [memGeomPkg::addrBits-1:0] dataAddr,
	input logic [memGeomPkg::wordBits-1:0] dataWdata,
	output logic dataAck,
	output logic [memGeomPkg::wordBits-1:0] dataRdata
);

	// per-port completion pulse, collector to arbiter
	logic [1:0] served;

	// one link per bank
	memBankIf bankLink [memGeomPkg::bankCount] ();

	portArbiter portArbiter_inst (
		.clk(clk),
		.rst(rst),
		.fetchReq(fetchReq),
		.fetchAddr(fetchAddr),
		.dataReq(dataReq),
		.dataWe(dataWe),
		.dataBe(dataBe),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.fetchAck(fetchAck),
		.dataAck(dataAck),
		.served(served),
		.banks(bankLink)
	);

	// identical banks, interleaved on word address
	for (genvar b = 0; b < memGeomPkg::bankCount; b++) begin : gBank
		memBank memBank_inst (
			.clk(clk),
			.port(bankLink[b])
		);
	end

	responseCollector responseCollector_inst (
		.clk(clk),
		.rst(rst),
		.banks(bankLink),
		.fetchReq(fetchReq),
		.dataReq(dataReq),
		.fetchAck(fetchAck),
		.fetchData(fetchData),
		.dataAck(dataAck),
		.dataRdata(dataRdata),
		.served(served)
	);

endmodule : memSystem

// File: bench/memSystem_asserts.sv
/*
 * req/ack protocol checks on both memSystem ports, bound into the DUT
 */
module memSystemAsserts (
	input logic clk,
	input logic rst,
	input logic fetchReq,
	input logic [memGeomPkg::addrBits-1:0] fetchAddr,
	input logic fetchAck,
	input logic dataReq,
	input logic dataWe,
	input logic [memGeomPkg::byteLanes-1:0] dataBe,
	input logic [memGeomPkg::addrBits-1:0] dataAddr,
	input logic [memGeomPkg::wordBits-1:0] dataWdata,
	input logic dataAck
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int fieldBits = 1 + memGeomPkg::byteLanes + memGeomPkg::addrBits +
		memGeomPkg::wordBits;

	// per-port views, fetch at 0 and data at 1
	logic [1:0] req;
	logic [1:0] ack;
	logic [fieldBits-1:0] fields [2];
	// failures so far, summed up by the testbench
	int failCount = 0;

	assign req = {dataReq, fetchReq};
	assign ack = {dataAck, fetchAck};
	// fetch carries only an address, upper bits stay zero
	assign fields[0] = {{(fieldBits - memGeomPkg::addrBits){1'b0}}, fetchAddr};
	assign fields[1] = {dataWe, dataBe, dataAddr, dataWdata};

	for (genvar p = 0; p < 2; p++) begin : gPort
		// ack only answers a pending request, req seen at the edge that raised ack
		ackRise: assert property (
			@(posedge clk) disable iff (rst) $rose(ack[p]) |-> $past(req[p])
		) else begin
			failCount++;
			$error("port %0d ack rose while req was low", p);
		end
		// ack holds while the requester still holds req
		ackHold: assert property (
			@(posedge clk) disable iff (rst) ack[p] && req[p] |=> ack[p]
		) else begin
			failCount++;
			$error("port %0d ack dropped before req went low", p);
		end
		// one edge after req is seen low, ack is gone
		ackFall: assert property (
			@(posedge clk) disable iff (rst) ack[p] && !req[p] |=> !ack[p]
		) else begin
			failCount++;
			$error("port %0d ack stayed high after req went low", p);
		end
		// requester keeps address and write fields steady until ack
		fieldsStable: assert property (
			@(posedge clk) disable iff (rst) req[p] && !ack[p] |=> $stable(fields[p])
		) else begin
			failCount++;
			$error("port %0d request fields changed before ack", p);
		end
	end

endmodule : memSystemAsserts

// File: bench/memSystemTb.sv
/*
 * testbench for memSystem, plays the core on the fetch and data ports
 * shadow memory compare, watchdog and one summary line
 */
module memSystemTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int idxBits = memGeomPkg::bankBits + memGeomPkg::rowBits;
	localparam int highBits = memGeomPkg::addrBits - memGeomPkg::offsetBits - idxBits;
	localparam int laneBits = memGeomPkg::wordBits / memGeomPkg::byteLanes;
	// words that get filled first and are used by every later access
	localparam int poolSize = 32;
	localparam int pairRounds = 24;
	// uncontested ack after 2 cycles, one conflict loss adds one
	localparam int maxWait = 3;
	localparam int ackLimit = 8;
	localparam int txnCount = 4 * poolSize + 4 * pairRounds + 8;
	localparam int cycleBound = 12;
	localparam int watchdogNs = (txnCount * cycleBound + 20) * 4;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic fetchReq = 1'b0;
	logic [memGeomPkg::addrBits-1:0] fetchAddr = '0;
	logic fetchAck;
	logic [memGeomPkg::wordBits-1:0] fetchData;
	logic dataReq = 1'b0;
	logic dataWe = 1'b0;
	logic [memGeomPkg::byteLanes-1:0] dataBe = '0;
	logic [memGeomPkg::addrBits-1:0] dataAddr = '0;
	logic [memGeomPkg::wordBits-1:0] dataWdata = '0;
	logic dataAck;
	logic [memGeomPkg::wordBits-1:0] dataRdata;

	// expected contents, one entry per word index
	logic [memGeomPkg::wordBits-1:0] shadow [memGeomPkg::bankCount * memGeomPkg::bankDepth];
	logic [15:0] lfsr = 16'd54759;
	int errors = 0;
	int assertFails;
	// cycles the last access on each port waited for ack
	int fetchWait = 0;
	int dataWait = 0;

	memSystem memSystem_inst (.*);

	bind memSystem memSystemAsserts memSystemAsserts_inst (.*);

	always #2 clk = ~clk;

	// galois lfsr, one step per bit handed out
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	// word index above the byte offset, random bits above it alias
	function automatic logic [memGeomPkg::addrBits-1:0] makeAddr(input int idx);
		logic [memGeomPkg::addrBits-1:0] a;
		a = randBits(highBits) << (memGeomPkg::offsetBits + idxBits);
		a[memGeomPkg::offsetBits +: idxBits] = idx[idxBits-1:0];
		return a;
	endfunction

	function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] nw,
		input logic [memGeomPkg::byteLanes-1:0] be);
		logic [31:0] m;
		m = old;
		for (int l = 0; l < memGeomPkg::byteLanes; l++) begin
			if (be[l]) m[l * laneBits +: laneBits] = nw[l * laneBits +: laneBits];
		end
		return m;
	endfunction

	task automatic checkWord(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// one read on the fetch port, optionally holding req after ack
	task automatic fetchRead(input logic [memGeomPkg::addrBits-1:0] addr, input int hold);
		logic [31:0] held;
		int waited;
		@(negedge clk);
		fetchAddr = addr;
		fetchReq = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!fetchAck && waited < ackLimit);
		fetchWait = waited;
		if (waited > maxWait) begin
			$display("fetch to %h waited %0d cycles for ack, too long", addr, waited);
			errors++;
		end
		if (fetchAck) begin
			checkWord("fetch word", fetchData, shadow[addr[memGeomPkg::offsetBits +: idxBits]]);
			held = fetchData;
			repeat (hold) begin
				@(negedge clk);
				checkWord("held fetch ack", fetchAck, 1'b1);
				checkWord("held fetch word", fetchData, held);
			end
		end
		fetchReq = 1'b0;
		while (fetchAck) begin
			@(negedge clk);
		end
	endtask

	// one data port access; writes update the shadow, reads compare with it
	task automatic dataAccess(input logic we, input logic [memGeomPkg::byteLanes-1:0] be,
		input logic [memGeomPkg::addrBits-1:0] addr, input logic [31:0] wdata, input int hold);
		logic [31:0] held;
		int waited;
		int idx;
		idx = addr[memGeomPkg::offsetBits +: idxBits];
		@(negedge clk);
		dataWe = we;
		dataBe = be;
		dataAddr = addr;
		dataWdata = wdata;
		dataReq = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!dataAck && waited < ackLimit);
		dataWait = waited;
		if (waited > maxWait) begin
			$display("data access to %h waited %0d cycles for ack, too long", addr, waited);
			errors++;
		end
		if (dataAck) begin
			if (we) begin
				shadow[idx] = mergeLanes(shadow[idx], wdata, be);
			end else begin
				checkWord("data word", dataRdata, shadow[idx]);
			end
			held = dataRdata;
			repeat (hold) begin
				@(negedge clk);
				checkWord("held data ack", dataAck, 1'b1);
				checkWord("held data word", dataRdata, held);
			end
		end
		dataReq = 1'b0;
		while (dataAck) begin
			@(negedge clk);
		end
	endtask

	initial begin
		logic [memGeomPkg::addrBits-1:0] fa;
		logic [memGeomPkg::addrBits-1:0] da;
		logic [31:0] wd;
		logic [memGeomPkg::byteLanes-1:0] be;
		logic we;
		int idx;
		logic [1:0] loser;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// no request yet, so no ack either
		repeat (4) begin
			@(negedge clk);
			checkWord("ack while idle", {fetchAck, dataAck}, '0);
		end
		// fill the pool with full words
		for (int i = 0; i < poolSize; i++) begin
			dataAccess(1'b1, '1, makeAddr(i), randBits(32), 0);
		end
		// read back through both ports
		for (int i = 0; i < poolSize; i++) begin
			dataAccess(1'b0, '0, makeAddr(i), '0, 0);
			fetchRead(makeAddr(i), 0);
		end
		// partial lane writes, each read back
		for (int i = 0; i < poolSize / 2; i++) begin
			idx = randBits($clog2(poolSize));
			dataAccess(1'b1, randBits(memGeomPkg::byteLanes), makeAddr(idx), randBits(32), 0);
			dataAccess(1'b0, '0, makeAddr(idx), '0, 0);
		end
		// fetch holds priority after reset, so data loses the first conflict
		loser = 2'b10;
		// concurrent pairs, different banks first, then one bank apart only by row
		for (int i = 0; i < 2 * pairRounds; i++) begin
			idx = randBits($clog2(poolSize));
			fa = makeAddr(idx);
			da = (i < pairRounds) ? makeAddr(idx ^ 1) : makeAddr(idx ^ memGeomPkg::bankCount);
			we = randBits(1);
			be = randBits(memGeomPkg::byteLanes);
			wd = randBits(32);
			fork
				fetchRead(fa, 0);
				dataAccess(we, be, da, wd, 0);
			join
			if (i >= pairRounds) begin
				// one port loses the bank each round, and the loser alternates
				checkWord("conflict losers", {dataWait == maxWait, fetchWait == maxWait}, loser);
				loser = ~loser;
			end
		end
		// req held past ack on both ports
		for (int i = 0; i < 4; i++) begin
			fa = makeAddr(i);
			da = makeAddr(i + 8);
			fork
				fetchRead(fa, 3);
				dataAccess(1'b0, '0, da, '0, 3);
			join
		end
		assertFails = memSystem_inst.memSystemAsserts_inst.failCount;
		$display("summary: %0d data errors, %0d assertion failures", errors, assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog sized from the transaction count
	initial begin
		#(watchdogNs);
		$display("timeout: the run did not finish within %0d ns", watchdogNs);
		$display("Verification failed");
		$finish;
	end

endmodule : memSystemTb

// File: memSystem.f
verilog/memGeomPkg.sv
verilog/memXactPkg.sv
verilog/memBankIf.sv
verilog/portArbiter.sv
verilog/memBank.sv
verilog/responseCollector.sv
verilog/memSystem.sv
bench/memSystem_asserts.sv
bench/memSystemTb.sv

// File: Makefile
# Verilator build and run for the memSystem testbench
SRCS := $(wildcard verilog/*.sv bench/*.sv)

# rebuilt only when a source or the file list changes
obj_dir/VmemSystemTb: memSystem.f $(SRCS)
	verilator --binary -j 0 --timing --assert -Wno-fatal --top-module memSystemTb -f memSystem.f

# the log decides the result
run: obj_dir/VmemSystemTb
	./obj_dir/VmemSystemTb +verilator+error+limit+1000 | tee sim.log
	@! grep -q "Verification failed" sim.log
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
